// ==== logic/decode_pkg.sv ====
package decode_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_w     = 32;	// Register and operand width
	localparam int reg_addr_w = 5;	// 32 registers, r0 reads zero
	localparam int opcode_w   = 6;
	localparam int shamt_w    = 5;
	localparam int imm_i_w    = 16;	// I-type immediate
	localparam int imm_j_w    = 21;	// J-type immediate, whole low field
	localparam int aluop_w    = 5;

	//////////////////////////////////////////////////////////////////////
	// Instruction word
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [opcode_w-1:0]   opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [shamt_w-1:0]    shamt;
		logic [5:0]            unused;
	} r_fmt_t;

	typedef struct packed {
		logic [opcode_w-1:0]   opcode;
		logic [reg_addr_w-1:0] rd;
		logic [imm_j_w-1:0]    imm;	// Low 16 bits double as I-type imm
	} i_fmt_t;

	// Same 32 bits, read as register or immediate layout
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam logic [opcode_w-1:0] op_nop = 6'b111111;

	// Groups, taken from the top opcode bits
	localparam logic       op_alu_grp    = 1'b1;	// Bit 5 alone
	localparam logic [2:0] op_pc_grp     = 3'b000;
	localparam logic [2:0] op_mem_grp    = 3'b001;
	localparam logic [2:0] op_audio_grp  = 3'b010;	// Reserved
	localparam logic [2:0] op_sprite_grp = 3'b011;

	localparam logic [opcode_w-1:0] op_call = 6'b000100;
	localparam logic [opcode_w-1:0] op_ret  = 6'b000101;
	localparam logic [opcode_w-1:0] op_jreg = 6'b000110;
	localparam logic [opcode_w-1:0] op_lw   = 6'b001000;
	localparam logic [opcode_w-1:0] op_li   = 6'b001001;
	localparam logic [opcode_w-1:0] op_pop  = 6'b001010;
	localparam logic [opcode_w-1:0] op_sw   = 6'b001100;
	localparam logic [opcode_w-1:0] op_push = 6'b001110;

	// ALU second operand source
	localparam logic [1:0] src_reg   = 2'b00;
	localparam logic [1:0] src_imm   = 2'b01;
	localparam logic [1:0] src_shamt = 2'b10;
	localparam logic [1:0] src_none  = 2'b11;

	localparam logic [aluop_w-1:0] aluop_add = 5'b00000;
	localparam logic [aluop_w-1:0] aluop_sub = 5'b00010;
	localparam logic [aluop_w-1:0] aluop_nop = 5'b10000;

	localparam logic [1:0] branch_always_never = 2'b11;	// Non-branch cond

endpackage

// ==== logic/ctrl_if.sv ====
interface ctrl_if;

	// PC and stack control
	logic       call;
	logic       ret;
	logic       branch;
	logic [1:0] branch_cond;
	logic       push;
	logic       pop;
	logic       jreg;

	// Operand and writeback routing
	logic       reg_2_sel;	// 1 picks rt, 0 picks rd
	logic       mem_to_reg;
	logic       mem_src;	// Memory address from operand B
	logic       load_imm;
	logic       sign_ext_sel;	// 1 picks J-type immediate
	logic [1:0] alu_src;

	// Strobes
	logic reg_write;
	logic mem_write;
	logic mem_read;
	logic oam_write;

	logic                             rd_1_en;	// Operand A is read
	logic                             rd_2_en;	// Second register is read
	logic [decode_pkg::aluop_w-1:0]   alu_op;

	modport decoder (
		output call, ret, branch, branch_cond, push, pop, jreg,
		output reg_2_sel, mem_to_reg, mem_src, load_imm, sign_ext_sel, alu_src,
		output reg_write, mem_write, mem_read, oam_write,
		output rd_1_en, rd_2_en, alu_op
	);

	modport stage (
		input call, ret, branch, branch_cond, push, pop, jreg,
		input reg_2_sel, mem_to_reg, mem_src, load_imm, sign_ext_sel, alu_src,
		input reg_write, mem_write, mem_read, oam_write,
		input rd_1_en, rd_2_en, alu_op
	);

endinterface

// ==== logic/operand_if.sv ====
interface operand_if;

	// Register file reads, bypass already applied
	logic [decode_pkg::data_w-1:0] rs_data;
	logic [decode_pkg::data_w-1:0] rt_data;
	logic [decode_pkg::data_w-1:0] rd_data;

	logic [decode_pkg::data_w-1:0] shamt_ext;	// Zero extended
	logic [decode_pkg::data_w-1:0] imm_i_ext;	// Sign extended from 16
	logic [decode_pkg::data_w-1:0] imm_j_ext;	// Sign extended from 21

	logic [decode_pkg::reg_addr_w-1:0] dest;

	modport fetch (
		output rs_data, rt_data, rd_data,
		output shamt_ext, imm_i_ext, imm_j_ext, dest
	);

	modport stage (
		input rs_data, rt_data, rd_data,
		input shamt_ext, imm_i_ext, imm_j_ext, dest
	);

endinterface

// ==== logic/control_decoder.sv ====
module control_decoder (
	input  logic [decode_pkg::opcode_w-1:0] opcode,
	ctrl_if.decoder                          ctrl
);

	always_comb begin
		// Idle word, the NOP and audio result
		ctrl.call         = 1'b0;
		ctrl.ret          = 1'b0;
		ctrl.branch       = 1'b0;
		ctrl.branch_cond  = decode_pkg::branch_always_never;
		ctrl.push         = 1'b0;
		ctrl.pop          = 1'b0;
		ctrl.jreg         = 1'b0;
		ctrl.reg_2_sel    = 1'b0;
		ctrl.mem_to_reg   = 1'b0;
		ctrl.mem_src      = 1'b0;
		ctrl.load_imm     = 1'b0;
		ctrl.sign_ext_sel = 1'b0;
		ctrl.alu_src      = decode_pkg::src_none;
		ctrl.reg_write    = 1'b0;
		ctrl.mem_write    = 1'b0;
		ctrl.mem_read     = 1'b0;
		ctrl.oam_write    = 1'b0;
		ctrl.rd_1_en      = 1'b0;
		ctrl.rd_2_en      = 1'b0;
		ctrl.alu_op       = decode_pkg::aluop_nop;

		//////////////////////////////////////////////////////////////////
		// ALU group
		//////////////////////////////////////////////////////////////////
		if (opcode[5] == decode_pkg::op_alu_grp) begin
			if (opcode != decode_pkg::op_nop) begin	// All ones stays idle
				ctrl.reg_write = 1'b1;
				ctrl.reg_2_sel = 1'b1;	// Second source is rt
				ctrl.rd_1_en   = 1'b1;
				ctrl.alu_op    = opcode[decode_pkg::aluop_w-1:0];	// ALU reads op directly

				// ADDI, ANDI style
				if (!opcode[1] && opcode[0]) begin
					ctrl.alu_src = decode_pkg::src_imm;
				end
				// Shifts by shamt
				else if (opcode[1] && opcode[2]) begin
					ctrl.alu_src = decode_pkg::src_shamt;
				end
				else begin
					ctrl.alu_src = decode_pkg::src_reg;	// rs op rt
					ctrl.rd_2_en = 1'b1;
				end
			end
		end
		else begin
			case (opcode[5:3])

				//////////////////////////////////////////////////////////
				// PC control
				//////////////////////////////////////////////////////////
				decode_pkg::op_pc_grp: begin
					ctrl.sign_ext_sel = 1'b1;	// Targets use the J immediate

					if (!opcode[2]) begin
						// PC plus offset, cond in low bits
						ctrl.branch      = 1'b1;
						ctrl.branch_cond = opcode[1:0];
						ctrl.alu_src     = decode_pkg::src_imm;
						ctrl.alu_op      = decode_pkg::aluop_add;
					end
					else if (opcode == decode_pkg::op_jreg) begin
						ctrl.jreg    = 1'b1;	// PC from rs
						ctrl.rd_1_en = 1'b1;
						ctrl.alu_src = decode_pkg::src_reg;
						ctrl.alu_op  = decode_pkg::aluop_add;
					end
					else if (opcode == decode_pkg::op_call || opcode == decode_pkg::op_ret) begin
						// SP in rs, step of one in shamt
						ctrl.reg_write = 1'b1;	// SP update
						ctrl.rd_1_en   = 1'b1;
						ctrl.alu_src   = decode_pkg::src_shamt;
						ctrl.call      = (opcode == decode_pkg::op_call);
						ctrl.ret       = (opcode == decode_pkg::op_ret);
						ctrl.mem_src   = (opcode == decode_pkg::op_call);
						ctrl.mem_write = (opcode == decode_pkg::op_call);	// Return addr pushed
						ctrl.mem_read  = (opcode == decode_pkg::op_ret);
						if (opcode == decode_pkg::op_call) begin
							ctrl.alu_op = decode_pkg::aluop_sub;	// SP - 1
						end
						else begin
							ctrl.alu_op = decode_pkg::aluop_add;	// SP + 1
						end
					end
				end

				//////////////////////////////////////////////////////////
				// Memory access
				//////////////////////////////////////////////////////////
				decode_pkg::op_mem_grp: begin
					case (opcode)
						decode_pkg::op_lw, decode_pkg::op_li, decode_pkg::op_pop: begin
							ctrl.reg_write  = 1'b1;
							ctrl.reg_2_sel  = 1'b1;
							ctrl.rd_1_en    = 1'b1;
							ctrl.alu_op     = decode_pkg::aluop_add;
							ctrl.load_imm   = (opcode == decode_pkg::op_li);	// No memory trip
							ctrl.mem_to_reg = (opcode != decode_pkg::op_li);
							ctrl.mem_read   = (opcode != decode_pkg::op_li);
							ctrl.pop        = (opcode == decode_pkg::op_pop);
							if (opcode == decode_pkg::op_pop) begin
								ctrl.alu_src = decode_pkg::src_shamt;	// SP + 1
							end
							else begin
								ctrl.alu_src = decode_pkg::src_imm;	// Base plus offset
							end
						end
						decode_pkg::op_sw, decode_pkg::op_push: begin
							ctrl.mem_write = 1'b1;
							ctrl.rd_1_en   = 1'b1;
							ctrl.rd_2_en   = 1'b1;	// Store data from rd
							ctrl.push      = (opcode == decode_pkg::op_push);
							ctrl.reg_write = (opcode == decode_pkg::op_push);	// SP update
							ctrl.mem_src   = (opcode == decode_pkg::op_push);
							if (opcode == decode_pkg::op_push) begin
								ctrl.alu_src = decode_pkg::src_shamt;
								ctrl.alu_op  = decode_pkg::aluop_sub;
							end
							else begin
								ctrl.alu_src = decode_pkg::src_imm;
								ctrl.alu_op  = decode_pkg::aluop_add;
							end
						end
						default: ;	// Unused memory codes stay idle
					endcase
				end

				// Reserved audio ops
				decode_pkg::op_audio_grp: ;

				// Sprite attribute writes
				decode_pkg::op_sprite_grp: begin
					ctrl.oam_write = 1'b1;
					ctrl.reg_2_sel = opcode[2];
					ctrl.alu_op    = decode_pkg::aluop_add;
				end

				default: ;
			endcase
		end
	end

endmodule

// ==== logic/operand_fetch.sv ====
module operand_fetch (
	input  logic                              clk,
	input  logic                              rst_n,
	input  decode_pkg::instr_t                instr,
	input  logic                              wb_en,
	input  logic [decode_pkg::reg_addr_w-1:0] wb_addr,
	input  logic [decode_pkg::data_w-1:0]     wb_data,
	operand_if.fetch                          ops
);

	// r0 has no storage
	logic [decode_pkg::data_w-1:0] regs [1:2**decode_pkg::reg_addr_w-1];

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 2**decode_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wb_en && wb_addr != '0) begin	// Writes to r0 dropped
			regs[wb_addr] <= wb_data;
		end
	end

	// One read port, with bypass of the write in flight
	function automatic logic [decode_pkg::data_w-1:0] read_port(
		input logic [decode_pkg::reg_addr_w-1:0] addr
	);
		logic [decode_pkg::data_w-1:0] val;
		if (addr == '0) begin
			val = '0;
		end
		else if (wb_en && wb_addr == addr) begin
			val = wb_data;	// Write-through
		end
		else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		ops.rs_data = read_port(instr.r.rs);
		ops.rt_data = read_port(instr.r.rt);
		ops.rd_data = read_port(instr.r.rd);	// Store data for SW, PUSH
	end

	//////////////////////////////////////////////////////////////////////
	// Field extension
	//////////////////////////////////////////////////////////////////////

	assign ops.shamt_ext = {{(decode_pkg::data_w - decode_pkg::shamt_w){1'b0}},
		instr.r.shamt};
	assign ops.imm_i_ext = {{(decode_pkg::data_w - decode_pkg::imm_i_w){instr.i.imm[decode_pkg::imm_i_w-1]}},
		instr.i.imm[decode_pkg::imm_i_w-1:0]};
	assign ops.imm_j_ext = {{(decode_pkg::data_w - decode_pkg::imm_j_w){instr.i.imm[decode_pkg::imm_j_w-1]}},
		instr.i.imm};

	assign ops.dest = instr.r.rd;

endmodule

// ==== logic/id_ex_register.sv ====
module id_ex_register (
	input  logic                              clk,
	input  logic                              rst_n,
	ctrl_if.stage                             ctrl,
	operand_if.stage                          ops,

	// Control for execute
	output logic                              ex_call,
	output logic                              ex_ret,
	output logic                              ex_branch,
	output logic [1:0]                        ex_branch_cond,
	output logic                              ex_push,
	output logic                              ex_pop,
	output logic                              ex_jreg,
	output logic                              ex_mem_to_reg,
	output logic                              ex_mem_src,
	output logic                              ex_load_imm,
	output logic                              ex_reg_write,
	output logic                              ex_mem_write,
	output logic                              ex_mem_read,
	output logic                              ex_oam_write,
	output logic [decode_pkg::aluop_w-1:0]    ex_alu_op,
	output logic [1:0]                        ex_alu_src,

	// Operands
	output logic [decode_pkg::reg_addr_w-1:0] ex_dest,
	output logic [decode_pkg::data_w-1:0]     ex_operand_a,
	output logic [decode_pkg::data_w-1:0]     ex_operand_b,
	output logic [decode_pkg::data_w-1:0]     ex_store_data,
	output logic [decode_pkg::data_w-1:0]     ex_imm
);

	logic [decode_pkg::data_w-1:0] reg_2_val;	// rt or rd
	logic [decode_pkg::data_w-1:0] operand_a;
	logic [decode_pkg::data_w-1:0] store_data;
	logic [decode_pkg::data_w-1:0] imm_sel;
	logic [decode_pkg::data_w-1:0] operand_b;

	//////////////////////////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////////////////////////

	assign reg_2_val  = ctrl.reg_2_sel ? ops.rt_data : ops.rd_data;
	assign operand_a  = ctrl.rd_1_en ? ops.rs_data : '0;	// Unread ports masked
	assign store_data = ctrl.rd_2_en ? reg_2_val : '0;
	assign imm_sel    = ctrl.sign_ext_sel ? ops.imm_j_ext : ops.imm_i_ext;

	always_comb begin
		case (ctrl.alu_src)
			decode_pkg::src_reg:   operand_b = store_data;
			decode_pkg::src_imm:   operand_b = imm_sel;
			decode_pkg::src_shamt: operand_b = ops.shamt_ext;	// SP step for stack ops
			default:               operand_b = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_call        <= 1'b0;
			ex_ret         <= 1'b0;
			ex_branch      <= 1'b0;
			ex_branch_cond <= decode_pkg::branch_always_never;
			ex_push        <= 1'b0;
			ex_pop         <= 1'b0;
			ex_jreg        <= 1'b0;
			ex_mem_to_reg  <= 1'b0;
			ex_mem_src     <= 1'b0;
			ex_load_imm    <= 1'b0;
			ex_reg_write   <= 1'b0;
			ex_mem_write   <= 1'b0;
			ex_mem_read    <= 1'b0;
			ex_oam_write   <= 1'b0;
			ex_alu_op      <= decode_pkg::aluop_nop;
			ex_alu_src     <= decode_pkg::src_none;
			ex_dest        <= '0;
			ex_operand_a   <= '0;
			ex_operand_b   <= '0;
			ex_store_data  <= '0;
			ex_imm         <= '0;
		end
		else begin
			ex_call        <= ctrl.call;
			ex_ret         <= ctrl.ret;
			ex_branch      <= ctrl.branch;
			ex_branch_cond <= ctrl.branch_cond;
			ex_push        <= ctrl.push;
			ex_pop         <= ctrl.pop;
			ex_jreg        <= ctrl.jreg;
			ex_mem_to_reg  <= ctrl.mem_to_reg;
			ex_mem_src     <= ctrl.mem_src;
			ex_load_imm    <= ctrl.load_imm;
			ex_reg_write   <= ctrl.reg_write;
			ex_mem_write   <= ctrl.mem_write;
			ex_mem_read    <= ctrl.mem_read;
			ex_oam_write   <= ctrl.oam_write;
			ex_alu_op      <= ctrl.alu_op;
			ex_alu_src     <= ctrl.alu_src;
			ex_dest        <= ops.dest;
			ex_operand_a   <= operand_a;
			ex_operand_b   <= operand_b;
			ex_store_data  <= store_data;	// Data to store for SW and PUSH
			ex_imm         <= imm_sel;
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [decode_pkg::data_w-1:0]     instr,

	// Writeback port
	input  logic                              wb_en,
	input  logic [decode_pkg::reg_addr_w-1:0] wb_addr,
	input  logic [decode_pkg::data_w-1:0]     wb_data,

	// To execute, one cycle after the instruction
	output logic                              ex_call,
	output logic                              ex_ret,
	output logic                              ex_branch,
	output logic [1:0]                        ex_branch_cond,
	output logic                              ex_push,
	output logic                              ex_pop,
	output logic                              ex_jreg,
	output logic                              ex_mem_to_reg,
	output logic                              ex_mem_src,
	output logic                              ex_load_imm,
	output logic                              ex_reg_write,
	output logic                              ex_mem_write,
	output logic                              ex_mem_read,
	output logic                              ex_oam_write,
	output logic [decode_pkg::aluop_w-1:0]    ex_alu_op,
	output logic [1:0]                        ex_alu_src,
	output logic [decode_pkg::reg_addr_w-1:0] ex_dest,
	output logic [decode_pkg::data_w-1:0]     ex_operand_a,
	output logic [decode_pkg::data_w-1:0]     ex_operand_b,
	output logic [decode_pkg::data_w-1:0]     ex_store_data,
	output logic [decode_pkg::data_w-1:0]     ex_imm
);

	decode_pkg::instr_t instr_word;	// Both field layouts

	assign instr_word = instr;

	ctrl_if    ctrl ();
	operand_if ops ();

	// Decoder and fetch run side by side
	control_decoder u_control_decoder (
		.opcode (instr_word.r.opcode),
		.ctrl   (ctrl)
	);

	operand_fetch u_operand_fetch (
		.clk     (clk),
		.rst_n   (rst_n),
		.instr   (instr_word),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.ops     (ops)
	);

	// Names match one to one
	id_ex_register u_id_ex_register (.*);

endmodule

// ==== tb/decode_stage_tb.sv ====
module decode_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	logic        ex_call, ex_ret, ex_branch, ex_push, ex_pop, ex_jreg;
	logic        ex_mem_to_reg, ex_mem_src, ex_load_imm;
	logic        ex_reg_write, ex_mem_write, ex_mem_read, ex_oam_write;
	logic [1:0]  ex_branch_cond;
	logic [4:0]  ex_alu_op;
	logic [1:0]  ex_alu_src;
	logic [4:0]  ex_dest;
	logic [31:0] ex_operand_a, ex_operand_b, ex_store_data, ex_imm;

	// Stimulus table, one entry per index
	string       row_name[$];
	logic [31:0] row_instr[$];
	logic        row_wb_en[$];
	logic [4:0]  row_wb_addr[$];
	logic [31:0] row_wb_data[$];
	logic [12:0] row_strobes[$];	// call ret branch push pop jreg m2r msrc limm rw mw mr oam
	logic [1:0]  row_cond[$];
	logic [4:0]  row_alu_op[$];
	logic [1:0]  row_alu_src[$];
	logic [3:0]  row_route[$];	// rd_1_en rd_2_en reg_2_sel sign_ext_sel

	// Predicted operands, filled as rows are driven
	logic [31:0] exp_a[$];
	logic [31:0] exp_b[$];
	logic [31:0] exp_store[$];
	logic [31:0] exp_imm[$];

	logic [31:0] reg_model [0:31];	// Register file as seen by the testbench
	logic        table_built = 1'b0;

	decode_stage UUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction words and register model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_word(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {op, rd, rs, rt, shamt, 6'b0};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic logic [31:0] j_word(input logic [5:0] op, input logic [4:0] rd,
		input logic [20:0] imm);
		return {op, rd, imm};
	endfunction

	// r0 reads zero, a write in the same cycle reads through
	function automatic logic [31:0] model_read(input logic [4:0] addr, input logic wb_e,
		input logic [4:0] wb_a, input logic [31:0] wb_d);
		if (addr == 5'd0)
			return 32'h0;
		if (wb_e && wb_a == addr)
			return wb_d;
		return reg_model[addr];
	endfunction

	task automatic add_row(input string name, input logic [31:0] word, input logic wb_e,
		input logic [4:0] wb_a, input logic [31:0] wb_d, input logic [12:0] strobes,
		input logic [1:0] cond, input logic [4:0] aop, input logic [1:0] asrc,
		input logic [3:0] route);
		row_name.push_back(name);
		row_instr.push_back(word);
		row_wb_en.push_back(wb_e);
		row_wb_addr.push_back(wb_a);
		row_wb_data.push_back(wb_d);
		row_strobes.push_back(strobes);
		row_cond.push_back(cond);
		row_alu_op.push_back(aop);
		row_alu_src.push_back(asrc);
		row_route.push_back(route);
	endtask

	// Operand selection rules applied to the model, then writeback
	task automatic predict(input int i);
		logic [31:0] w;
		logic [31:0] rs_v, rt_v, rd_v, reg2, imm, b;
		w    = row_instr[i];
		rs_v = model_read(w[20:16], row_wb_en[i], row_wb_addr[i], row_wb_data[i]);
		rt_v = model_read(w[15:11], row_wb_en[i], row_wb_addr[i], row_wb_data[i]);
		rd_v = model_read(w[25:21], row_wb_en[i], row_wb_addr[i], row_wb_data[i]);
		reg2 = row_route[i][1] ? rt_v : rd_v;
		imm  = row_route[i][0] ? {{11{w[20]}}, w[20:0]} : {{16{w[15]}}, w[15:0]};
		exp_a.push_back(row_route[i][3] ? rs_v : 32'h0);
		exp_store.push_back(row_route[i][2] ? reg2 : 32'h0);
		exp_imm.push_back(imm);
		case (row_alu_src[i])
			decode_pkg::src_reg:   b = row_route[i][2] ? reg2 : 32'h0;
			decode_pkg::src_imm:   b = imm;
			decode_pkg::src_shamt: b = {27'h0, w[10:6]};
			default:               b = 32'h0;
		endcase
		exp_b.push_back(b);
		if (row_wb_en[i] && row_wb_addr[i] != 5'd0)
			reg_model[row_wb_addr[i]] = row_wb_data[i];
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string test, input string field,
		input logic [31:0] exp_v, input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("ERROR %s: %s expected %h, actual %h", test, field, exp_v, act_v);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_outputs(input string test, input logic [12:0] strobes,
		input logic [1:0] cond, input logic [4:0] aop, input logic [1:0] asrc,
		input logic [4:0] dest, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] st, input logic [31:0] imm);
		check_value(test, "strobes", strobes, {ex_call, ex_ret, ex_branch, ex_push, ex_pop,
			ex_jreg, ex_mem_to_reg, ex_mem_src, ex_load_imm, ex_reg_write, ex_mem_write,
			ex_mem_read, ex_oam_write});
		check_value(test, "branch_cond", cond, ex_branch_cond);
		check_value(test, "alu_op", aop, ex_alu_op);
		check_value(test, "alu_src", asrc, ex_alu_src);
		check_value(test, "dest", dest, ex_dest);
		check_value(test, "operand_a", a, ex_operand_a);
		check_value(test, "operand_b", b, ex_operand_b);
		check_value(test, "store_data", st, ex_store_data);
		check_value(test, "imm", imm, ex_imm);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		logic [31:0] nop_w;
		nop_w = r_word(decode_pkg::op_nop, 5'd0, 5'd0, 5'd0, 5'd0);
		for (int r = 1; r < 8; r++) begin	// Random register contents
			add_row($sformatf("fill_r%0d", r), nop_w, 1'b1, r[4:0], $urandom(),
				13'b000_000_000_0000, 2'b11, decode_pkg::aluop_nop, decode_pkg::src_none, 4'b0000);
		end
		add_row("fill_sp", nop_w, 1'b1, 5'd29, $urandom(),
			13'b000_000_000_0000, 2'b11, decode_pkg::aluop_nop, decode_pkg::src_none, 4'b0000);

		// ALU group
		add_row("add", r_word(6'b100000, 5'd3, 5'd1, 5'd2, 5'd0), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00000, decode_pkg::src_reg, 4'b1110);
		add_row("addi", i_word(6'b100001, 5'd4, 5'd2, 16'hFF80), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00001, decode_pkg::src_imm, 4'b1010);
		add_row("sub", r_word(6'b100010, 5'd5, 5'd3, 5'd4, 5'd0), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00010, decode_pkg::src_reg, 4'b1110);
		add_row("sll", r_word(6'b100110, 5'd6, 5'd5, 5'd1, 5'd7), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00110, decode_pkg::src_shamt, 4'b1010);

		// Branches, one per condition
		add_row("branch_c0", j_word(6'b000000, 5'd0, 21'h000040), 1'b0, 5'd0, 32'h0,
			13'b001_000_000_0000, 2'b00, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b0001);
		add_row("branch_c1_neg", j_word(6'b000001, 5'd0, 21'h1FFFF0), 1'b0, 5'd0, 32'h0,
			13'b001_000_000_0000, 2'b01, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b0001);
		add_row("branch_c2", j_word(6'b000010, 5'd0, 21'h0ABCDE), 1'b0, 5'd0, 32'h0,
			13'b001_000_000_0000, 2'b10, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b0001);
		add_row("branch_c3", j_word(6'b000011, 5'd0, 21'h100000), 1'b0, 5'd0, 32'h0,
			13'b001_000_000_0000, 2'b11, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b0001);
		add_row("jreg", r_word(decode_pkg::op_jreg, 5'd0, 5'd5, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0,
			13'b000_001_000_0000, 2'b11, decode_pkg::aluop_add, decode_pkg::src_reg, 4'b1001);

		// Stack operations, SP in rs and a step of 1 in shamt
		add_row("call", r_word(decode_pkg::op_call, 5'd29, 5'd29, 5'd0, 5'd1), 1'b0, 5'd0, 32'h0,
			13'b100_000_010_1100, 2'b11, decode_pkg::aluop_sub, decode_pkg::src_shamt, 4'b1001);
		add_row("ret", r_word(decode_pkg::op_ret, 5'd29, 5'd29, 5'd0, 5'd1), 1'b0, 5'd0, 32'h0,
			13'b010_000_000_1010, 2'b11, decode_pkg::aluop_add, decode_pkg::src_shamt, 4'b1001);
		add_row("push", r_word(decode_pkg::op_push, 5'd3, 5'd29, 5'd0, 5'd1), 1'b0, 5'd0, 32'h0,
			13'b000_100_010_1100, 2'b11, decode_pkg::aluop_sub, decode_pkg::src_shamt, 4'b1100);
		add_row("pop", r_word(decode_pkg::op_pop, 5'd4, 5'd29, 5'd0, 5'd1), 1'b0, 5'd0, 32'h0,
			13'b000_010_100_1010, 2'b11, decode_pkg::aluop_add, decode_pkg::src_shamt, 4'b1010);

		// Memory, sprite and audio
		add_row("sw", i_word(decode_pkg::op_sw, 5'd4, 5'd2, 16'h0010), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_0100, 2'b11, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b1100);
		add_row("lw", i_word(decode_pkg::op_lw, 5'd5, 5'd2, 16'hFFFC), 1'b0, 5'd0, 32'h0,
			13'b000_000_100_1010, 2'b11, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b1010);
		add_row("li", i_word(decode_pkg::op_li, 5'd6, 5'd0, 16'h1234), 1'b0, 5'd0, 32'h0,
			13'b000_000_001_1000, 2'b11, decode_pkg::aluop_add, decode_pkg::src_imm, 4'b1010);
		add_row("sprite", r_word(6'b011100, 5'd7, 5'd1, 5'd2, 5'd3), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_0001, 2'b11, decode_pkg::aluop_add, decode_pkg::src_none, 4'b0010);
		add_row("audio", r_word(6'b010101, 5'd9, 5'd3, 5'd4, 5'd5), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_0000, 2'b11, decode_pkg::aluop_nop, decode_pkg::src_none, 4'b0000);

		// Write-through and r0
		add_row("bypass_rs", r_word(6'b100000, 5'd8, 5'd1, 5'd2, 5'd0), 1'b1, 5'd1, $urandom(),
			13'b000_000_000_1000, 2'b11, 5'b00000, decode_pkg::src_reg, 4'b1110);
		add_row("after_bypass", r_word(6'b100010, 5'd8, 5'd1, 5'd1, 5'd0), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00010, decode_pkg::src_reg, 4'b1110);
		add_row("r0_write", r_word(6'b100000, 5'd6, 5'd0, 5'd2, 5'd0), 1'b1, 5'd0, 32'hDEADBEEF,
			13'b000_000_000_1000, 2'b11, 5'b00000, decode_pkg::src_reg, 4'b1110);
		add_row("r0_after", r_word(6'b100000, 5'd6, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0,
			13'b000_000_000_1000, 2'b11, 5'b00000, decode_pkg::src_reg, 4'b1110);
		add_row("nop", nop_w, 1'b0, 5'd0, 32'h0,
			13'b000_000_000_0000, 2'b11, decode_pkg::aluop_nop, decode_pkg::src_none, 4'b0000);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////////////////////////

	initial begin
		int n;
		void'($urandom(13994));
		rst_n   = 1'b0;
		instr   = r_word(decode_pkg::op_nop, 5'd0, 5'd0, 5'd0, 5'd0);
		wb_en   = 1'b0;
		wb_addr = 5'd0;
		wb_data = 32'h0;
		for (int r = 0; r < 32; r++)
			reg_model[r] = 32'h0;
		build_table();
		n = row_name.size();
		table_built = 1'b1;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_outputs("reset", 13'h0, 2'b11, decode_pkg::aluop_nop, decode_pkg::src_none,
			5'd0, 32'h0, 32'h0, 32'h0, 32'h0);

		// One row per clock, each checked after the edge that captures it
		for (int i = 0; i <= n; i++) begin
			@(posedge clk);
			if (i < n) begin
				instr   <= row_instr[i];
				wb_en   <= row_wb_en[i];
				wb_addr <= row_wb_addr[i];
				wb_data <= row_wb_data[i];
				predict(i);
			end
			else begin
				instr <= r_word(decode_pkg::op_nop, 5'd0, 5'd0, 5'd0, 5'd0);
				wb_en <= 1'b0;
			end
			@(negedge clk);
			if (i > 0)
				check_outputs(row_name[i-1], row_strobes[i-1], row_cond[i-1], row_alu_op[i-1],
					row_alu_src[i-1], row_instr[i-1][25:21], exp_a[i-1], exp_b[i-1],
					exp_store[i-1], exp_imm[i-1]);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

	// Watchdog, scaled to the table length
	initial begin
		wait (table_built);
		#((row_name.size() + 10) * 8);
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout: the test sequence did not finish in time");
	end

endmodule

// ==== list.f ====
logic/decode_pkg.sv
logic/ctrl_if.sv
logic/operand_if.sv
logic/control_decoder.sv
logic/operand_fetch.sv
logic/id_ex_register.sv
logic/decode_stage.sv
tb/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/ctrl_if.sv
  - logic/operand_if.sv
  - logic/control_decoder.sv
  - logic/operand_fetch.sv
  - logic/id_ex_register.sv
  - logic/decode_stage.sv
  - target: simulation
    files:
      - tb/decode_stage_tb.sv
